// File: flist.f
+incdir+include
logic/glb_pkg.sv
logic/glb_bank.sv
logic/glb_strm_counter.sv
logic/glb_strm_fsm.sv
logic/glb_tile.sv
logic/global_buffer.sv
verification/tb_global_buffer.sv

// File: include/glb_macros.svh
// global buffer size and width macros, included by the package and by any module that sizes ports
`ifndef GLB_MACROS_SVH
`define GLB_MACROS_SVH

// number of tiles in the chain
`define GLB_NUM_TILES 2

// bank word and byte strobes
`define GLB_BANK_DATA_WIDTH 64
`define GLB_BANK_STRB_WIDTH 8

// word address within one bank, 256 words deep
`define GLB_BANK_ADDR_WIDTH 8

// processor byte address: tile select, word address, byte offset
`define GLB_TILE_SEL_WIDTH 1
`define GLB_BYTE_OFFSET_WIDTH 3
`define GLB_ADDR_WIDTH 12

// configuration data
`define GLB_CFG_DATA_WIDTH 16

`endif

// File: logic/glb_bank.sv
// one 256-word memory bank with a byte-strobed processor port and a separate stream read port
`default_nettype none

`include "glb_macros.svh"

module glb_bank (
    input  logic                            clk,
    input  logic                            wr_en,
    input  logic [`GLB_BANK_STRB_WIDTH-1:0] wr_strb,
    input  glb_pkg::bank_addr_t             wr_addr,
    input  glb_pkg::bank_data_t             wr_data,
    input  logic                            rd_en,
    input  glb_pkg::bank_addr_t             rd_addr,
    output glb_pkg::bank_data_t             rd_data,
    input  logic                            strm_rd_en,
    input  glb_pkg::bank_addr_t             strm_rd_addr,
    output glb_pkg::strm_word_t             stream_g2f
);

    localparam int DEPTH  = 1 << `GLB_BANK_ADDR_WIDTH;
    localparam int BYTE_W = `GLB_BANK_DATA_WIDTH / `GLB_BANK_STRB_WIDTH;

    glb_pkg::bank_data_t mem [DEPTH];

    // byte-wise write under the strobes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `GLB_BANK_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*BYTE_W +: BYTE_W] <= wr_data[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // processor read data appears one cycle after the request
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // stream read with valid following the request
    always_ff @(posedge clk) begin
        stream_g2f.valid <= strm_rd_en;
        if (strm_rd_en) begin
            stream_g2f.data <= mem[strm_rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/glb_pkg.sv
// shared packet, configuration and stream types for the global buffer tiles and top level
`default_nettype none

`include "glb_macros.svh"

package glb_pkg;

    typedef logic [`GLB_BANK_DATA_WIDTH-1:0] bank_data_t;
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // processor write request
    typedef struct packed {
        logic                            wr_en;
        logic [`GLB_BANK_STRB_WIDTH-1:0] wr_strb;
        logic [`GLB_ADDR_WIDTH-1:0]      wr_addr;
        bank_data_t                      wr_data;
    } proc_wr_t;

    // processor read request
    typedef struct packed {
        logic                       rd_en;
        logic [`GLB_ADDR_WIDTH-1:0] rd_addr;
    } proc_rdrq_t;

    // processor read response
    typedef struct packed {
        bank_data_t rd_data;
        logic       rd_data_valid;
    } proc_rdrs_t;

    // tile-to-tile packet, rdrs trails wr and rdrq by one cycle
    typedef struct packed {
        proc_wr_t   wr;
        proc_rdrq_t rdrq;
        proc_rdrs_t rdrs;
    } proc_packet_t;

    typedef enum logic [0:0] {
        CFG_STRM_START_ADDR = 1'b0,
        CFG_STRM_NUM_WORDS  = 1'b1
    } cfg_reg_e;

    // broadcast configuration write
    typedef struct packed {
        logic                           wr_en;
        logic [`GLB_TILE_SEL_WIDTH-1:0] tile;
        cfg_reg_e                       cfg_reg;
        logic [`GLB_CFG_DATA_WIDTH-1:0] data;
    } cfg_wr_t;

    typedef enum logic [0:0] {
        STRM_IDLE = 1'b0,
        STRM_RUN  = 1'b1
    } strm_state_e;

    // one word streamed out to the fabric
    typedef struct packed {
        bank_data_t data;
        logic       valid;
    } strm_word_t;

endpackage

`default_nettype wire

// File: logic/glb_strm_counter.sv
// stream address and remaining-word counter, loaded at stream start and stepped once per word
`default_nettype none

`include "glb_macros.svh"

module glb_strm_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           load,
    input  logic                           step,
    input  glb_pkg::bank_addr_t            start_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] num_words,
    output glb_pkg::bank_addr_t            addr,
    output logic                           last
);

    localparam logic [`GLB_CFG_DATA_WIDTH-1:0] ONE_WORD = 1;

    // words still to be read, including the current one
    logic [`GLB_CFG_DATA_WIDTH-1:0] remain;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr   <= '0;
            remain <= '0;
        end else if (load) begin
            addr   <= start_addr;
            remain <= num_words;
        end else if (step) begin
            // address wraps at the bank end
            addr   <= addr + 1'b1;
            remain <= remain - 1'b1;
        end
    end

    assign last = (remain == ONE_WORD);

endmodule

`default_nettype wire

// File: logic/glb_strm_fsm.sv
// stream control FSM; starts a stream on an accepted pulse and steps the counter and bank reads
`default_nettype none

`include "glb_macros.svh"

module glb_strm_fsm (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start_pulse,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0] num_words,
    input  logic                           last,
    output logic                           load,
    output logic                           step,
    output logic                           done_pulse
);

    glb_pkg::strm_state_e state;
    glb_pkg::strm_state_e state_next;

    // accepted start, only when idle and there is something to send
    logic start_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= glb_pkg::STRM_IDLE;
            start_q    <= 1'b0;
            done_pulse <= 1'b0;
        end else begin
            state      <= state_next;
            start_q    <= start_pulse && (state == glb_pkg::STRM_IDLE) && (num_words != '0);
            // bank output lags the step by one cycle
            done_pulse <= step && last;
        end
    end

    // a second pulse right behind the first finds the FSM already running
    assign load = start_q && (state == glb_pkg::STRM_IDLE);
    assign step = (state == glb_pkg::STRM_RUN);

    always_comb begin
        state_next = state;
        case (state)
            glb_pkg::STRM_IDLE: begin
                if (load) begin
                    state_next = glb_pkg::STRM_RUN;
                end
            end
            glb_pkg::STRM_RUN: begin
                if (last) begin
                    state_next = glb_pkg::STRM_IDLE;
                end
            end
            default: begin
                state_next = glb_pkg::STRM_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/glb_tile.sv
// one buffer tile; serves processor packets passing east, holds stream config and streams its bank
`default_nettype none

`include "glb_macros.svh"

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  glb_pkg::proc_packet_t packet_wsti,
    output glb_pkg::proc_packet_t packet_esto,
    input  glb_pkg::cfg_wr_t      cfg_wr,
    input  logic                  strm_start_pulse,
    output glb_pkg::strm_word_t   stream_g2f,
    output logic                  interrupt_pulse
);

    localparam logic [`GLB_TILE_SEL_WIDTH-1:0] TILE_SEL = TILE_ID[`GLB_TILE_SEL_WIDTH-1:0];
    localparam int SEL_LSB  = `GLB_ADDR_WIDTH - `GLB_TILE_SEL_WIDTH;
    localparam int WORD_LSB = `GLB_BYTE_OFFSET_WIDTH;

    logic                  wr_hit;
    logic                  rd_hit;
    logic                  rd_hit_q;
    glb_pkg::bank_addr_t   wr_word_addr;
    glb_pkg::bank_addr_t   rd_word_addr;
    glb_pkg::bank_data_t   bank_rd_data;
    glb_pkg::proc_rdrs_t   rdrs_next;
    glb_pkg::proc_packet_t packet_q;

    glb_pkg::bank_addr_t            strm_start_addr;
    logic [`GLB_CFG_DATA_WIDTH-1:0] strm_num_words;
    logic                           strm_load;
    logic                           strm_step;
    logic                           strm_last;
    glb_pkg::bank_addr_t            strm_addr;

    // tile select and word address decode, byte offset dropped
    assign wr_hit = packet_wsti.wr.wr_en &&
                    (packet_wsti.wr.wr_addr[SEL_LSB +: `GLB_TILE_SEL_WIDTH] == TILE_SEL);
    assign rd_hit = packet_wsti.rdrq.rd_en &&
                    (packet_wsti.rdrq.rd_addr[SEL_LSB +: `GLB_TILE_SEL_WIDTH] == TILE_SEL);

    assign wr_word_addr = packet_wsti.wr.wr_addr[WORD_LSB +: `GLB_BANK_ADDR_WIDTH];
    assign rd_word_addr = packet_wsti.rdrq.rd_addr[WORD_LSB +: `GLB_BANK_ADDR_WIDTH];

    // configuration registers
    always_ff @(posedge clk) begin
        if (rst) begin
            strm_start_addr <= '0;
            strm_num_words  <= '0;
        end else if (cfg_wr.wr_en && (cfg_wr.tile == TILE_SEL)) begin
            case (cfg_wr.cfg_reg)
                glb_pkg::CFG_STRM_START_ADDR: begin
                    strm_start_addr <= cfg_wr.data[`GLB_BANK_ADDR_WIDTH-1:0];
                end
                glb_pkg::CFG_STRM_NUM_WORDS: begin
                    strm_num_words <= cfg_wr.data;
                end
                default: begin
                    strm_num_words <= strm_num_words;
                end
            endcase
        end
    end

    // response field runs one cycle behind the request fields,
    // so the bank data of last cycle's hit joins the upstream response here
    always_comb begin
        rdrs_next = packet_wsti.rdrs;
        if (rd_hit_q) begin
            rdrs_next.rd_data       = bank_rd_data;
            rdrs_next.rd_data_valid = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        packet_q.wr   <= packet_wsti.wr;
        packet_q.rdrq <= packet_wsti.rdrq;
        packet_q.rdrs <= rdrs_next;
        rd_hit_q      <= rd_hit;
        if (rst) begin
            packet_q.wr.wr_en           <= 1'b0;
            packet_q.rdrq.rd_en         <= 1'b0;
            packet_q.rdrs.rd_data_valid <= 1'b0;
            rd_hit_q                    <= 1'b0;
        end
    end

    assign packet_esto = packet_q;

    glb_bank u_glb_bank (
        .clk          (clk),
        .wr_en        (wr_hit),
        .wr_strb      (packet_wsti.wr.wr_strb),
        .wr_addr      (wr_word_addr),
        .wr_data      (packet_wsti.wr.wr_data),
        .rd_en        (rd_hit),
        .rd_addr      (rd_word_addr),
        .rd_data      (bank_rd_data),
        .strm_rd_en   (strm_step),
        .strm_rd_addr (strm_addr),
        .stream_g2f   (stream_g2f)
    );

    glb_strm_fsm u_glb_strm_fsm (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (strm_start_pulse),
        .num_words   (strm_num_words),
        .last        (strm_last),
        .load        (strm_load),
        .step        (strm_step),
        .done_pulse  (interrupt_pulse)
    );

    glb_strm_counter u_glb_strm_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (strm_load),
        .step       (strm_step),
        .start_addr (strm_start_addr),
        .num_words  (strm_num_words),
        .addr       (strm_addr),
        .last       (strm_last)
    );

endmodule

`default_nettype wire

// File: logic/global_buffer.sv
// global buffer top level; feeds processor requests into a chain of tiles and exposes the streams
`default_nettype none

`include "glb_macros.svh"

module global_buffer (
    input  logic                                         clk,
    input  logic                                         rst,

    // processor port
    input  logic                                         proc_wr_en,
    input  logic [`GLB_BANK_STRB_WIDTH-1:0]              proc_wr_strb,
    input  logic [`GLB_ADDR_WIDTH-1:0]                   proc_wr_addr,
    input  glb_pkg::bank_data_t                          proc_wr_data,
    input  logic                                         proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]                   proc_rd_addr,
    output glb_pkg::bank_data_t                          proc_rd_data,
    output logic                                         proc_rd_data_valid,

    // configuration, broadcast to every tile
    input  glb_pkg::cfg_wr_t                             cfg_wr,

    // streams and pulses, one per tile
    input  logic [`GLB_NUM_TILES-1:0]                    strm_start_pulse,
    output glb_pkg::strm_word_t [`GLB_NUM_TILES-1:0]     stream_g2f,
    output logic [`GLB_NUM_TILES-1:0]                    interrupt_pulse
);

    glb_pkg::proc_packet_t packet_west;
    glb_pkg::proc_packet_t packet_east [`GLB_NUM_TILES];

    // packet entering tile 0, no response yet
    always_comb begin
        packet_west.wr.wr_en     = proc_wr_en;
        packet_west.wr.wr_strb   = proc_wr_strb;
        packet_west.wr.wr_addr   = proc_wr_addr;
        packet_west.wr.wr_data   = proc_wr_data;
        packet_west.rdrq.rd_en   = proc_rd_en;
        packet_west.rdrq.rd_addr = proc_rd_addr;
        packet_west.rdrs         = '0;
    end

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        glb_pkg::proc_packet_t packet_in;

        if (i == 0) begin : g_first
            assign packet_in = packet_west;
        end else begin : g_chain
            assign packet_in = packet_east[i-1];
        end

        glb_tile #(
            .TILE_ID (i)
        ) u_glb_tile (
            .clk              (clk),
            .rst              (rst),
            .packet_wsti      (packet_in),
            .packet_esto      (packet_east[i]),
            .cfg_wr           (cfg_wr),
            .strm_start_pulse (strm_start_pulse[i]),
            .stream_g2f       (stream_g2f[i]),
            .interrupt_pulse  (interrupt_pulse[i])
        );
    end

    // read responses leave from the east end of the chain
    assign proc_rd_data       = packet_east[`GLB_NUM_TILES-1].rdrs.rd_data;
    assign proc_rd_data_valid = packet_east[`GLB_NUM_TILES-1].rdrs.rd_data_valid;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the global buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_global_buffer \
    -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_global_buffer)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verification/tb_global_buffer.sv
// testbench for the global buffer; applies a stimulus table and checks it against a model
`default_nettype none

`include "glb_macros.svh"

module tb_global_buffer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_TIMEOUT  = 16;
    localparam int STREAM_TIMEOUT = 40;
    localparam int QUIET_CYCLES   = 8;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_CONFIG, OP_STREAM, OP_IDLE} op_e;

    // addr is a byte address, or the tile for config and stream entries
    // data is the start address for config
    // nonzero data on a stream asks for a repeat pulse
    // count is the word count for config or the cycles to watch for idle
    typedef struct packed {
        op_e                             kind;
        logic [`GLB_ADDR_WIDTH-1:0]      addr;
        logic [`GLB_CFG_DATA_WIDTH-1:0]  data;
        logic [`GLB_BANK_STRB_WIDTH-1:0] strb;
        logic [`GLB_CFG_DATA_WIDTH-1:0]  count;
    } entry_t;

    logic                                     clk = 1'b0;
    logic                                     rst;
    logic                                     proc_wr_en;
    logic [`GLB_BANK_STRB_WIDTH-1:0]          proc_wr_strb;
    logic [`GLB_ADDR_WIDTH-1:0]               proc_wr_addr;
    glb_pkg::bank_data_t                      proc_wr_data;
    logic                                     proc_rd_en;
    logic [`GLB_ADDR_WIDTH-1:0]               proc_rd_addr;
    glb_pkg::bank_data_t                      proc_rd_data;
    logic                                     proc_rd_data_valid;
    glb_pkg::cfg_wr_t                         cfg_wr;
    logic [`GLB_NUM_TILES-1:0]                strm_start_pulse;
    glb_pkg::strm_word_t [`GLB_NUM_TILES-1:0] stream_g2f;
    logic [`GLB_NUM_TILES-1:0]                interrupt_pulse;

    // reference model state
    glb_pkg::bank_data_t            ref_mem [`GLB_NUM_TILES][1 << `GLB_BANK_ADDR_WIDTH];
    glb_pkg::bank_addr_t            ref_start [`GLB_NUM_TILES];
    logic [`GLB_CFG_DATA_WIDTH-1:0] ref_count [`GLB_NUM_TILES];

    glb_pkg::bank_data_t exp_data [$];
    int unsigned         exp_cycle [$];
    entry_t              table_q [$];
    string               test_names [$];

    int          seed = 56900;
    int unsigned cycle = 0;
    bit          monitor_on = 1'b0;
    bit          timed_out = 1'b0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_idx = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    global_buffer u_global_buffer (
        .clk                (clk),
        .rst                (rst),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr             (cfg_wr),
        .strm_start_pulse   (strm_start_pulse),
        .stream_g2f         (stream_g2f),
        .interrupt_pulse    (interrupt_pulse)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [`GLB_ADDR_WIDTH-1:0] byte_addr(
            input logic [`GLB_TILE_SEL_WIDTH-1:0] tile, input glb_pkg::bank_addr_t word);
        return {tile, word, {`GLB_BYTE_OFFSET_WIDTH{1'b0}}};
    endfunction

    function automatic logic [`GLB_TILE_SEL_WIDTH-1:0] tile_of(
            input logic [`GLB_ADDR_WIDTH-1:0] addr);
        return addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH];
    endfunction

    function automatic glb_pkg::bank_addr_t word_of(input logic [`GLB_ADDR_WIDTH-1:0] addr);
        return addr[`GLB_BYTE_OFFSET_WIDTH +: `GLB_BANK_ADDR_WIDTH];
    endfunction

    // only strobed bytes take the new value
    function automatic glb_pkg::bank_data_t merge_bytes(input glb_pkg::bank_data_t old_word,
            input glb_pkg::bank_data_t new_word, input logic [`GLB_BANK_STRB_WIDTH-1:0] strb);
        glb_pkg::bank_data_t merged;
        merged = old_word;
        for (int b = 0; b < `GLB_BANK_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_rd_data(input glb_pkg::bank_data_t actual,
                                 input glb_pkg::bank_data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0d ns: read data %h, expected %h", $time, actual, expected);
        end
    endtask

    // data is only compared when a valid word is expected
    task automatic check_stream_word(input glb_pkg::strm_word_t actual,
                                     input glb_pkg::strm_word_t expected);
        check_count++;
        if (actual.valid !== expected.valid ||
            (expected.valid && actual.data !== expected.data)) begin
            error_count++;
            $display("** Error at %0d ns: stream word valid %b data %h, expected valid %b data %h",
                     $time, actual.valid, actual.data, expected.valid, expected.data);
        end
    endtask

    task automatic check_interrupt(input bit actual, input bit expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0d ns: interrupt %b, expected %b", $time, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        timed_out = 1'b1;
        $display("timeout at %0d ns: %s", $time, what);
    endtask

    task automatic clear_inputs();
        proc_wr_en       = 1'b0;
        proc_wr_strb     = '0;
        proc_wr_addr     = '0;
        proc_wr_data     = '0;
        proc_rd_en       = 1'b0;
        proc_rd_addr     = '0;
        cfg_wr           = '0;
        strm_start_pulse = '0;
    endtask

    task automatic add_entry(input op_e kind, input logic [`GLB_ADDR_WIDTH-1:0] addr,
            input logic [`GLB_CFG_DATA_WIDTH-1:0] data,
            input logic [`GLB_BANK_STRB_WIDTH-1:0] strb,
            input logic [`GLB_CFG_DATA_WIDTH-1:0] count);
        entry_t e;
        e.kind  = kind;
        e.addr  = addr;
        e.data  = data;
        e.strb  = strb;
        e.count = count;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // zero word count on tile 0 must stay silent
        add_entry(OP_STREAM, 12'd0, 16'd0, 8'h00, 16'd0);
        add_entry(OP_IDLE, 12'd0, 16'd0, 8'h00, 16'd4);
        test_names.push_back("reset");
        add_entry(OP_WRITE, byte_addr(1'b0, 8'd3), 16'd0, 8'hff, 16'd0);
        add_entry(OP_WRITE, byte_addr(1'b1, 8'd7), 16'd0, 8'hff, 16'd0);
        add_entry(OP_WRITE, byte_addr(1'b0, 8'd200), 16'd0, 8'hff, 16'd0);
        add_entry(OP_READ, byte_addr(1'b1, 8'd7), 16'd0, 8'h00, 16'd0);
        add_entry(OP_READ, byte_addr(1'b0, 8'd3), 16'd0, 8'h00, 16'd0);
        add_entry(OP_READ, byte_addr(1'b0, 8'd200), 16'd0, 8'h00, 16'd0);
        add_entry(OP_IDLE, 12'd0, 16'd0, 8'h00, 16'd2);
        test_names.push_back("write then read");
        add_entry(OP_WRITE, byte_addr(1'b0, 8'd3), 16'd0, 8'h0f, 16'd0);
        add_entry(OP_WRITE, byte_addr(1'b1, 8'd7), 16'd0, 8'ha5, 16'd0);
        add_entry(OP_READ, byte_addr(1'b0, 8'd3), 16'd0, 8'h00, 16'd0);
        // byte offset bits are ignored
        add_entry(OP_READ, byte_addr(1'b1, 8'd7) | 12'd5, 16'd0, 8'h00, 16'd0);
        add_entry(OP_WRITE, byte_addr(1'b0, 8'd200), 16'd0, 8'h80, 16'd0);
        add_entry(OP_READ, byte_addr(1'b0, 8'd200), 16'd0, 8'h00, 16'd0);
        add_entry(OP_IDLE, 12'd0, 16'd0, 8'h00, 16'd2);
        test_names.push_back("byte strobes");
        add_entry(OP_READ, byte_addr(1'b0, 8'd3), 16'd0, 8'h00, 16'd0);
        add_entry(OP_READ, byte_addr(1'b1, 8'd7), 16'd0, 8'h00, 16'd0);
        add_entry(OP_READ, byte_addr(1'b0, 8'd200), 16'd0, 8'h00, 16'd0);
        add_entry(OP_READ, byte_addr(1'b1, 8'd7), 16'd0, 8'h00, 16'd0);
        add_entry(OP_READ, byte_addr(1'b0, 8'd3), 16'd0, 8'h00, 16'd0);
        add_entry(OP_IDLE, 12'd0, 16'd0, 8'h00, 16'd2);
        test_names.push_back("back-to-back reads");
        for (int w = 253; w < 259; w++) begin
            add_entry(OP_WRITE, byte_addr(1'b1, glb_pkg::bank_addr_t'(w)), 16'd0, 8'hff, 16'd0);
        end
        add_entry(OP_CONFIG, 12'd1, 16'd254, 8'h00, 16'd5);
        add_entry(OP_STREAM, 12'd1, 16'd1, 8'h00, 16'd0);
        add_entry(OP_IDLE, 12'd0, 16'd0, 8'h00, 16'd8);
        test_names.push_back("streaming");
    endtask

    task automatic drive_write(input entry_t e);
        glb_pkg::bank_data_t data;
        data = {$random(seed), $random(seed)};
        proc_wr_en   = 1'b1;
        proc_wr_strb = e.strb;
        proc_wr_addr = e.addr;
        proc_wr_data = data;
        ref_mem[tile_of(e.addr)][word_of(e.addr)] =
            merge_bytes(ref_mem[tile_of(e.addr)][word_of(e.addr)], data, e.strb);
    endtask

    task automatic issue_read(input entry_t e);
        proc_rd_en   = 1'b1;
        proc_rd_addr = e.addr;
        exp_data.push_back(ref_mem[tile_of(e.addr)][word_of(e.addr)]);
        // sampled at the next edge and then one cycle per tile
        exp_cycle.push_back(cycle + 1 + `GLB_NUM_TILES);
    endtask

    // start address in the first cycle and word count in the second
    task automatic write_stream_config(input entry_t e);
        logic [`GLB_TILE_SEL_WIDTH-1:0] tsel;
        tsel = e.addr[`GLB_TILE_SEL_WIDTH-1:0];
        cfg_wr.wr_en   = 1'b1;
        cfg_wr.tile    = tsel;
        cfg_wr.cfg_reg = glb_pkg::CFG_STRM_START_ADDR;
        cfg_wr.data    = e.data;
        @(negedge clk);
        cfg_wr.cfg_reg = glb_pkg::CFG_STRM_NUM_WORDS;
        cfg_wr.data    = e.count;
        ref_start[tsel] = e.data[`GLB_BANK_ADDR_WIDTH-1:0];
        ref_count[tsel] = e.count;
    endtask

    task automatic run_stream(input entry_t e);
        logic [`GLB_TILE_SEL_WIDTH-1:0] tsel;
        glb_pkg::strm_word_t            expected;
        int unsigned                    start_cycle;
        int                             n;
        int                             idx;
        int                             waited;
        bit                             repeat_sent;
        tsel        = e.addr[`GLB_TILE_SEL_WIDTH-1:0];
        n           = int'(ref_count[tsel]);
        idx         = 0;
        waited      = 0;
        repeat_sent = 1'b0;
        expected    = '0;
        start_cycle = cycle;
        strm_start_pulse[tsel] = 1'b1;
        if (n == 0) begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                clear_inputs();
                check_stream_word(stream_g2f[tsel], expected);
                check_interrupt(interrupt_pulse[tsel], 1'b0);
            end
        end else begin
            while (idx < n && waited < STREAM_TIMEOUT) begin
                @(negedge clk);
                clear_inputs();
                waited++;
                if (stream_g2f[tsel].valid) begin
                    expected.data  = ref_mem[tsel][glb_pkg::bank_addr_t'(ref_start[tsel] + idx)];
                    expected.valid = 1'b1;
                    check_stream_word(stream_g2f[tsel], expected);
                    check_interrupt(interrupt_pulse[tsel], idx == n - 1);
                    // first word two cycles after the edge that samples the pulse
                    if (cycle != start_cycle + 3 + idx) begin
                        error_count++;
                        $display("** Error at %0d ns: stream word %0d in cycle %0d, expected %0d",
                                 $time, idx, cycle, start_cycle + 3 + idx);
                    end
                    idx++;
                end else begin
                    check_interrupt(interrupt_pulse[tsel], 1'b0);
                end
                // a start while running must be ignored
                if (e.data != '0 && !repeat_sent && idx == 2) begin
                    strm_start_pulse[tsel] = 1'b1;
                    repeat_sent = 1'b1;
                end
            end
            if (idx < n) begin
                report_timeout("stream ended before all words came out");
            end
        end
    endtask

    task automatic watch_idle(input entry_t e);
        glb_pkg::strm_word_t quiet;
        int                  waited;
        quiet  = '0;
        waited = 0;
        while (exp_cycle.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_cycle.size() != 0) begin
            report_timeout("read responses still pending");
        end else begin
            for (int c = 0; c < int'(e.count); c++) begin
                @(negedge clk);
                for (int t = 0; t < `GLB_NUM_TILES; t++) begin
                    check_stream_word(stream_g2f[t], quiet);
                    check_interrupt(interrupt_pulse[t], 1'b0);
                end
            end
            $display("test %0d %s: %0d checks, %0d errors", test_idx, test_names[test_idx],
                     check_count - test_checks, error_count - test_errors);
            test_idx++;
            test_checks = check_count;
            test_errors = error_count;
        end
    endtask

    // read responses matched in issue order
    always @(negedge clk) begin
        if (monitor_on) begin
            if (exp_cycle.size() != 0 && exp_cycle[0] < cycle) begin
                error_count++;
                $display("** Error at %0d ns: no read response in cycle %0d", $time, exp_cycle[0]);
                void'(exp_cycle.pop_front());
                void'(exp_data.pop_front());
            end
            if (proc_rd_data_valid) begin
                if (exp_cycle.size() == 0) begin
                    error_count++;
                    $display("** Error at %0d ns: read data valid with no read pending", $time);
                end else begin
                    if (exp_cycle[0] != cycle) begin
                        error_count++;
                        $display("** Error at %0d ns: read response in cycle %0d, expected %0d",
                                 $time, cycle, exp_cycle[0]);
                    end
                    check_rd_data(proc_rd_data, exp_data[0]);
                    void'(exp_cycle.pop_front());
                    void'(exp_data.pop_front());
                end
            end
        end
    end

    initial begin
        clear_inputs();
        rst = 1'b1;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            ref_start[t] = '0;
            ref_count[t] = '0;
        end
        build_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        monitor_on = 1'b1;
        for (int i = 0; i < table_q.size() && !timed_out; i++) begin
            @(negedge clk);
            clear_inputs();
            case (table_q[i].kind)
                OP_WRITE:  drive_write(table_q[i]);
                OP_READ:   issue_read(table_q[i]);
                OP_CONFIG: write_stream_config(table_q[i]);
                OP_STREAM: run_stream(table_q[i]);
                default:   watch_idle(table_q[i]);
            endcase
        end
        @(negedge clk);
        clear_inputs();
        $display("tests %0d, checks %0d, errors %0d", test_idx, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
